// File: rtl/menu_settings.svh
`ifndef MENU_SETTINGS_SVH
`define MENU_SETTINGS_SVH

// LCD geometry, two lines of 16 characters
`define LCD_LINE_CHARS 16
`define LCD_CHARS 32

// Field widths
`define LCD_ADDR_W 5
`define CHAR_W 8
`define MENU_ID_W 5
`define RAM_SEL_W 2

// Multi-bank RAM codes
`define RAM_SEL_MENU 2'd0
`define RAM_SEL_LOCAL 2'd2

// Menu pages stored in the menu bank
`define MENU_TITLE_MAIN 5'd0
`define MENU_OPTION_DISPLAY_LOCAL 5'd3
`define MENU_OPTION_CLEAR_LOCAL_RAM 5'd5
`define MENU_OPTION_I2C_ACTIONS 5'd6
`define MENU_TITLE_I2C_ACTIONS 5'd7
`define MENU_TITLE_ARE_YOU_SURE 5'd8
`define MENU_OPTION_YES 5'd9
`define MENU_OPTION_NO 5'd10
`define MENU_OPTION_WRITE_TO_REMOTE 5'd11
`define MENU_OPTION_READ_FROM_REMOTE 5'd12
`define MENU_TITLE_STATUS 5'd14
`define MENU_STATUS_WRITING 5'd15
`define MENU_STATUS_ACTION_COMPLETE 5'd16

`endif

// File: rtl/menuPkg.sv
`default_nettype none

`include "menu_settings.svh"

package menuPkg;

	// Character address on the LCD or in a RAM bank
	typedef logic [`LCD_ADDR_W-1:0] lcdAddr_t;
	// Character code
	typedef logic [`CHAR_W-1:0] lcdChar_t;
	// Page identifier inside the menu bank
	typedef logic [`MENU_ID_W-1:0] menuId_t;
	// RAM bank code
	typedef logic [`RAM_SEL_W-1:0] ramSel_t;

	// Menu sequencer states
	typedef enum logic [3:0] {
		refreshTitle,
		refreshOption,
		waitCopy,
		waitSelection,
		showLocal,
		waitReturn,
		clearConfirm,
		clearRam,
		remoteStart,
		remoteWait
	} navState_t;

endpackage

`default_nettype wire

// File: rtl/lcdCopyIf.sv
`timescale 1ns/10ps
`default_nettype none

interface lcdCopyIf
	import menuPkg::*;
();

	// One-cycle request and completion pulses
	logic start;
	logic done;
	// Copy range, held from start until done
	ramSel_t ramSel;
	menuId_t menuSel;
	lcdAddr_t firstAddr;
	lcdAddr_t lastAddr;

	// Menu FSM side
	modport sequencer (output start, ramSel, menuSel, firstAddr, lastAddr, input done);

	// Copy engine side
	modport engine (input start, ramSel, menuSel, firstAddr, lastAddr, output done);

endinterface

`default_nettype wire

// File: rtl/lcdRefresher.sv
`timescale 1ns/10ps
`default_nettype none

module lcdRefresher
	import menuPkg::*;
(
	input logic clk,
	input logic rst,
	lcdCopyIf.engine copy,
	output lcdAddr_t ramAddr,
	output lcdAddr_t lcdAddr,
	output logic lcdWrite
);

	// Copy in flight
	logic busy;
	// Low for the setup cycle, high for the write cycle
	logic writePhase;
	// Range accepted this cycle
	logic loadRange;
	// Last character of the range being written
	logic lastChar;

	assign loadRange = !busy && copy.start;
	assign lastChar = lcdAddr == copy.lastAddr;

	// RAM data settles during setup, LCD latches it in the write cycle
	assign lcdWrite = busy && writePhase;

	//////////////////////////////////////////////////////////////////////
	// Phase control
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			writePhase <= 1'b0;
			copy.done <= 1'b0;
		end
		else
		begin
			copy.done <= 1'b0;
			if (loadRange)
			begin
				busy <= 1'b1;
				writePhase <= 1'b0;
			end
			else if (busy)
			begin
				// Alternate setup and write
				writePhase <= !writePhase;
				// Finish after writing the last address
				if (writePhase && lastChar)
				begin
					busy <= 1'b0;
					copy.done <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address walk
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		// RAM side always starts at character 0
		if (loadRange)
		begin
			ramAddr <= '0;
			lcdAddr <= copy.firstAddr;
		end
		// Step both after each write except the last
		else if (lcdWrite && !lastChar)
		begin
			ramAddr <= ramAddr + 1'b1;
			lcdAddr <= lcdAddr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/menuNavigator.sv
`timescale 1ns/10ps
`default_nettype none

`include "menu_settings.svh"

module menuNavigator
	import menuPkg::*;
(
	input logic clk,
	input logic rst,
	lcdCopyIf.sequencer copy,
	input logic rotaryEvent,
	input logic rotaryLeft,
	input logic rotaryBtn,
	input logic menuBtn,
	input logic remoteDone,
	output logic ramClear,
	output logic remoteEnable,
	output logic remoteRw
);

	navState_t state;
	// State to enter once the running copy is done
	navState_t afterCopy;
	// Page shown on the option line
	menuId_t option;
	// Copy engine still working, tracked across menu button presses
	logic copyBusy;

	//////////////////////////////////////////////////////////////////////
	// Page tables
	//////////////////////////////////////////////////////////////////////

	// Title line belonging to each option page
	function automatic menuId_t titleOf(input menuId_t opt);
		case (opt)
			`MENU_OPTION_YES, `MENU_OPTION_NO:
				titleOf = `MENU_TITLE_ARE_YOU_SURE;
			`MENU_OPTION_WRITE_TO_REMOTE, `MENU_OPTION_READ_FROM_REMOTE:
				titleOf = `MENU_TITLE_I2C_ACTIONS;
			`MENU_STATUS_WRITING, `MENU_STATUS_ACTION_COMPLETE:
				titleOf = `MENU_TITLE_STATUS;
			default:
				titleOf = `MENU_TITLE_MAIN;
		endcase
	endfunction

	// Neighbour of an option for one knob step
	function automatic menuId_t stepOption(input menuId_t opt, input logic left);
		case (opt)
			// Main ring, left goes forward
			`MENU_OPTION_DISPLAY_LOCAL:
				stepOption = left ? `MENU_OPTION_CLEAR_LOCAL_RAM : `MENU_OPTION_I2C_ACTIONS;
			`MENU_OPTION_CLEAR_LOCAL_RAM:
				stepOption = left ? `MENU_OPTION_I2C_ACTIONS : `MENU_OPTION_DISPLAY_LOCAL;
			`MENU_OPTION_I2C_ACTIONS:
				stepOption = left ? `MENU_OPTION_DISPLAY_LOCAL : `MENU_OPTION_CLEAR_LOCAL_RAM;
			// Two-entry pages swap either way
			`MENU_OPTION_YES:
				stepOption = `MENU_OPTION_NO;
			`MENU_OPTION_NO:
				stepOption = `MENU_OPTION_YES;
			`MENU_OPTION_WRITE_TO_REMOTE:
				stepOption = `MENU_OPTION_READ_FROM_REMOTE;
			`MENU_OPTION_READ_FROM_REMOTE:
				stepOption = `MENU_OPTION_WRITE_TO_REMOTE;
			default:
				stepOption = opt;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Copy engine occupancy
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		// Mirrors the engine, which the menu button leaves running
		if (rst)
			copyBusy <= 1'b0;
		else if (copy.start)
			copyBusy <= 1'b1;
		else if (copy.done)
			copyBusy <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Menu FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst || menuBtn)
		begin
			state <= refreshTitle;
			afterCopy <= refreshOption;
			option <= `MENU_OPTION_DISPLAY_LOCAL;
			copy.start <= 1'b0;
			copy.ramSel <= `RAM_SEL_MENU;
			ramClear <= 1'b0;
			remoteEnable <= 1'b0;
			remoteRw <= 1'b0;
		end
		else
		begin
			copy.start <= 1'b0;
			ramClear <= 1'b0;
			// Remote done is taken in any state while enabled
			if (remoteEnable && remoteDone)
				remoteEnable <= 1'b0;
			case (state)
				refreshTitle:
					if (!copyBusy)
					begin
						copy.start <= 1'b1;
						copy.ramSel <= `RAM_SEL_MENU;
						copy.menuSel <= titleOf(option);
						copy.firstAddr <= '0;
						copy.lastAddr <= lcdAddr_t'(`LCD_LINE_CHARS - 1);
						afterCopy <= refreshOption;
						state <= waitCopy;
					end
				refreshOption:
					if (!copyBusy)
					begin
						copy.start <= 1'b1;
						copy.ramSel <= `RAM_SEL_MENU;
						copy.menuSel <= option;
						copy.firstAddr <= lcdAddr_t'(`LCD_LINE_CHARS);
						copy.lastAddr <= lcdAddr_t'(`LCD_CHARS - 1);
						// Writing page waits on the remote side, not the user
						afterCopy <= (option == `MENU_STATUS_WRITING) ? remoteWait : waitSelection;
						state <= waitCopy;
					end
				waitCopy:
					if (copy.done)
						state <= afterCopy;
				waitSelection:
					if (rotaryBtn)
					begin
						case (option)
							`MENU_OPTION_DISPLAY_LOCAL:
								state <= showLocal;
							`MENU_OPTION_CLEAR_LOCAL_RAM:
								state <= clearConfirm;
							`MENU_OPTION_I2C_ACTIONS:
							begin
								option <= `MENU_OPTION_WRITE_TO_REMOTE;
								state <= refreshTitle;
							end
							`MENU_OPTION_YES:
								state <= clearRam;
							`MENU_OPTION_WRITE_TO_REMOTE:
							begin
								remoteRw <= 1'b0;
								state <= remoteStart;
							end
							`MENU_OPTION_READ_FROM_REMOTE:
							begin
								remoteRw <= 1'b1;
								state <= remoteStart;
							end
							// NO and action complete go back to the main ring
							default:
							begin
								option <= `MENU_OPTION_DISPLAY_LOCAL;
								state <= refreshTitle;
							end
						endcase
					end
					else if (rotaryEvent && option != `MENU_STATUS_ACTION_COMPLETE)
					begin
						option <= stepOption(option, rotaryLeft);
						state <= refreshTitle;
					end
				showLocal:
					// Whole screen straight from the local bank
					if (!copyBusy)
					begin
						copy.start <= 1'b1;
						copy.ramSel <= `RAM_SEL_LOCAL;
						copy.firstAddr <= '0;
						copy.lastAddr <= lcdAddr_t'(`LCD_CHARS - 1);
						afterCopy <= waitReturn;
						state <= waitCopy;
					end
				waitReturn:
					if (rotaryBtn)
					begin
						option <= `MENU_OPTION_DISPLAY_LOCAL;
						state <= refreshTitle;
					end
				clearConfirm:
				begin
					option <= `MENU_OPTION_YES;
					state <= refreshTitle;
				end
				clearRam:
				begin
					// One-cycle clear with the local bank selected
					ramClear <= 1'b1;
					copy.ramSel <= `RAM_SEL_LOCAL;
					option <= `MENU_OPTION_DISPLAY_LOCAL;
					state <= refreshTitle;
				end
				remoteStart:
				begin
					remoteEnable <= 1'b1;
					option <= `MENU_STATUS_WRITING;
					state <= refreshTitle;
				end
				remoteWait:
					// Enable already dropped by remote done
					if (!remoteEnable)
					begin
						option <= `MENU_STATUS_ACTION_COMPLETE;
						state <= refreshTitle;
					end
				default:
					state <= refreshTitle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/menuTop.sv
`timescale 1ns/10ps
`default_nettype none

module menuTop
	import menuPkg::*;
(
	input logic clk,
	input logic rst,
	input logic rotaryEvent,
	input logic rotaryLeft,
	input logic rotaryBtn,
	input logic menuBtn,
	input logic remoteDone,
	input lcdChar_t ramDout,
	output lcdAddr_t lcdAddr,
	output lcdChar_t lcdData,
	output logic lcdWrite,
	output ramSel_t ramSel,
	output menuId_t menuSelect,
	output lcdAddr_t ramAddr,
	output logic ramClear,
	output logic remoteEnable,
	output logic remoteRw
);

	// Sequencer to copy engine link
	lcdCopyIf copyBus ();

	// Bank and page go straight to the external RAM
	assign ramSel = copyBus.ramSel;
	assign menuSelect = copyBus.menuSel;
	// RAM is read asynchronously, LCD takes its output as is
	assign lcdData = ramDout;

	//////////////////////////////////////////////////////////////////////
	// Menu FSM
	//////////////////////////////////////////////////////////////////////
	menuNavigator u_navigator (
		.clk(clk),
		.rst(rst),
		.copy(copyBus.sequencer),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.rotaryBtn(rotaryBtn),
		.menuBtn(menuBtn),
		.remoteDone(remoteDone),
		.ramClear(ramClear),
		.remoteEnable(remoteEnable),
		.remoteRw(remoteRw)
	);

	//////////////////////////////////////////////////////////////////////
	// LCD copy engine
	//////////////////////////////////////////////////////////////////////
	lcdRefresher u_refresher (
		.clk(clk),
		.rst(rst),
		.copy(copyBus.engine),
		.ramAddr(ramAddr),
		.lcdAddr(lcdAddr),
		.lcdWrite(lcdWrite)
	);

endmodule

`default_nettype wire

// File: bench/menuTb_sva.sv
`timescale 1ns/10ps
`default_nettype none

module menuTb_sva (
	input logic clk,
	input logic rst,
	input logic lcdWrite,
	input logic ramClear,
	input logic remoteEnable,
	input logic remoteRw,
	input logic remoteDone,
	input logic menuBtn
);

	// Number of failed checks so far
	int failCount = 0;

	// Clear strobe lasts one cycle
	clearOneCycle: assert property (@(posedge clk) disable iff (rst)
		ramClear |=> !ramClear)
		else
		begin
			failCount++;
			$error("ramClear stayed high for two cycles");
		end

	// Setup cycle between any two LCD writes
	writeSpacing: assert property (@(posedge clk) disable iff (rst)
		lcdWrite |=> !lcdWrite)
		else
		begin
			failCount++;
			$error("lcdWrite high in two consecutive cycles");
		end

	// Enable held until the remote side answers
	enableHeld: assert property (@(posedge clk) disable iff (rst)
		remoteEnable && !remoteDone && !menuBtn |=> remoteEnable)
		else
		begin
			failCount++;
			$error("remoteEnable fell without remoteDone");
		end

	// Direction frozen for the whole action
	rwStable: assert property (@(posedge clk) disable iff (rst)
		remoteEnable |=> !remoteEnable || $stable(remoteRw))
		else
		begin
			failCount++;
			$error("remoteRw changed while remoteEnable was high");
		end

endmodule

`default_nettype wire

// File: bench/menuTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "menu_settings.svh"

module menuTb
	import menuPkg::*;
();

	// Safety limit, roughly 20% above the longest expected run
	localparam int MaxCycles = 3000;

	logic clk = 1'b0;
	logic rst;
	logic rotaryEvent;
	logic rotaryLeft;
	logic rotaryBtn;
	logic menuBtn;
	logic remoteDone;
	lcdChar_t ramDout;
	lcdAddr_t lcdAddr;
	lcdChar_t lcdData;
	logic lcdWrite;
	ramSel_t ramSel;
	menuId_t menuSelect;
	lcdAddr_t ramAddr;
	logic ramClear;
	logic remoteEnable;
	logic remoteRw;

	// Local bank model and the screen as the LCD holds it
	lcdChar_t localMem [`LCD_CHARS];
	lcdChar_t screen [`LCD_CHARS];
	int writeCount = 0;
	int clearCount = 0;
	int cycleCount = 0;

	menuTop u_dut (.*);

	bind menuTop menuTb_sva u_sva (
		.clk(clk),
		.rst(rst),
		.lcdWrite(lcdWrite),
		.ramClear(ramClear),
		.remoteEnable(remoteEnable),
		.remoteRw(remoteRw),
		.remoteDone(remoteDone),
		.menuBtn(menuBtn)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// RAM model, screen monitor, timeout
	//////////////////////////////////////////////////////////////////////

	// Menu bank cell = page * 32 + position, low 8 bits
	function automatic lcdChar_t menuChar(input menuId_t id, input int pos);
		int code;
		code = id * `LCD_CHARS + pos;
		menuChar = code[`CHAR_W-1:0];
	endfunction

	// Asynchronous read
	always @*
	begin
		case (ramSel)
			`RAM_SEL_MENU: ramDout = menuChar(menuSelect, ramAddr);
			`RAM_SEL_LOCAL: ramDout = localMem[ramAddr];
			default: ramDout = '0;
		endcase
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (!rst && lcdWrite)
		begin
			screen[lcdAddr] <= lcdData;
			writeCount <= writeCount + 1;
		end
		// Clear only hits the local bank
		if (!rst && ramClear)
		begin
			clearCount <= clearCount + 1;
			if (ramSel == `RAM_SEL_LOCAL)
				for (int i = 0; i < `LCD_CHARS; i++)
					localMem[i] <= '0;
		end
		if (u_dut.u_sva.failCount != 0)
		begin
			$display("A bound assertion failed, the run stops here");
			$display("SOME TESTS FAILED");
			$fatal(1, "Simulation stopped by a failed assertion");
		end
		else if (cycleCount >= MaxCycles)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", MaxCycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "Simulation stopped by the timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and check helpers
	//////////////////////////////////////////////////////////////////////
	task automatic reportError(input string msg);
		$display("ERR %0t ns: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic turnKnob(input logic left);
		@(posedge clk);
		rotaryEvent <= 1'b1;
		rotaryLeft <= left;
		@(posedge clk);
		rotaryEvent <= 1'b0;
	endtask

	task automatic pressKnob();
		@(posedge clk);
		rotaryBtn <= 1'b1;
		@(posedge clk);
		rotaryBtn <= 1'b0;
	endtask

	task automatic pressMenu();
		@(posedge clk);
		menuBtn <= 1'b1;
		@(posedge clk);
		menuBtn <= 1'b0;
	endtask

	// Last cell written, then one cycle for done
	task automatic waitRefresh(input bit countWrites);
		int base;
		base = writeCount;
		do
			@(posedge clk);
		while (!(lcdWrite && lcdAddr == lcdAddr_t'(`LCD_CHARS - 1)));
		@(posedge clk);
		if (countWrites)
			assert (writeCount - base == `LCD_CHARS)
			else reportError($sformatf("%0d LCD writes in one refresh", writeCount - base));
	endtask

	task automatic checkPage(input menuId_t title, input menuId_t option);
		for (int i = 0; i < `LCD_LINE_CHARS; i++)
		begin
			assert (screen[i] == menuChar(title, i))
			else reportError($sformatf("title cell %0d is %h, page %0d expected",
				i, screen[i], title));
			assert (screen[i + `LCD_LINE_CHARS] == menuChar(option, i))
			else reportError($sformatf("option cell %0d is %h, page %0d expected",
				i, screen[i + `LCD_LINE_CHARS], option));
		end
	endtask

	// Whole screen against the local bank, or all blank after a clear
	task automatic checkLocal(input bit expectZero);
		for (int i = 0; i < `LCD_CHARS; i++)
			assert (screen[i] == (expectZero ? lcdChar_t'(0) : localMem[i]))
			else reportError($sformatf("local cell %0d shows %h", i, screen[i]));
	endtask

	task automatic stepTo(input logic left, input menuId_t title, input menuId_t option);
		turnKnob(left);
		waitRefresh(1'b1);
		checkPage(title, option);
	endtask

	task automatic selectTo(input menuId_t title, input menuId_t option);
		pressKnob();
		waitRefresh(1'b1);
		checkPage(title, option);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic testReset();
		waitRefresh(1'b1);
		checkPage(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
	endtask

	task automatic testRing();
		stepTo(1'b1, `MENU_TITLE_MAIN, `MENU_OPTION_CLEAR_LOCAL_RAM);
		stepTo(1'b1, `MENU_TITLE_MAIN, `MENU_OPTION_I2C_ACTIONS);
		stepTo(1'b1, `MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
		// Right turn goes back one
		stepTo(1'b0, `MENU_TITLE_MAIN, `MENU_OPTION_I2C_ACTIONS);
	endtask

	task automatic testShowLocal();
		stepTo(1'b1, `MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
		pressKnob();
		waitRefresh(1'b1);
		checkLocal(1'b0);
		selectTo(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
	endtask

	task automatic testClear();
		// NO path leaves the bank alone
		stepTo(1'b1, `MENU_TITLE_MAIN, `MENU_OPTION_CLEAR_LOCAL_RAM);
		selectTo(`MENU_TITLE_ARE_YOU_SURE, `MENU_OPTION_YES);
		stepTo(1'b0, `MENU_TITLE_ARE_YOU_SURE, `MENU_OPTION_NO);
		selectTo(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
		assert (clearCount == 0)
		else reportError($sformatf("%0d ramClear pulses after NO", clearCount));
		// YES path clears once
		stepTo(1'b1, `MENU_TITLE_MAIN, `MENU_OPTION_CLEAR_LOCAL_RAM);
		selectTo(`MENU_TITLE_ARE_YOU_SURE, `MENU_OPTION_YES);
		selectTo(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
		assert (clearCount == 1)
		else reportError($sformatf("%0d ramClear pulses after YES", clearCount));
		pressKnob();
		waitRefresh(1'b1);
		checkLocal(1'b1);
		selectTo(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
	endtask

	task automatic testRemote(input logic read);
		int delay;
		stepTo(1'b0, `MENU_TITLE_MAIN, `MENU_OPTION_I2C_ACTIONS);
		selectTo(`MENU_TITLE_I2C_ACTIONS, `MENU_OPTION_WRITE_TO_REMOTE);
		if (read)
			stepTo(1'b0, `MENU_TITLE_I2C_ACTIONS, `MENU_OPTION_READ_FROM_REMOTE);
		selectTo(`MENU_TITLE_STATUS, `MENU_STATUS_WRITING);
		assert (remoteEnable && remoteRw == read)
		else reportError($sformatf("enable %b rw %b at action start", remoteEnable, remoteRw));
		// Remote side answers late
		delay = 1 + $urandom % 20;
		repeat (delay)
		begin
			@(posedge clk);
			assert (remoteEnable)
			else reportError("remoteEnable fell before remoteDone");
		end
		remoteDone <= 1'b1;
		@(posedge clk);
		remoteDone <= 1'b0;
		waitRefresh(1'b1);
		checkPage(`MENU_TITLE_STATUS, `MENU_STATUS_ACTION_COMPLETE);
		assert (!remoteEnable)
		else reportError("remoteEnable still high after remoteDone");
		selectTo(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
	endtask

	task automatic testMenuButton();
		int base;
		// From the local view
		pressKnob();
		waitRefresh(1'b1);
		pressMenu();
		waitRefresh(1'b1);
		checkPage(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
		// Partway through the confirmation title copy
		stepTo(1'b1, `MENU_TITLE_MAIN, `MENU_OPTION_CLEAR_LOCAL_RAM);
		pressKnob();
		base = writeCount;
		do
			@(posedge clk);
		while (writeCount < base + 5);
		pressMenu();
		waitRefresh(1'b0);
		checkPage(`MENU_TITLE_MAIN, `MENU_OPTION_DISPLAY_LOCAL);
	endtask

	initial
	begin
		void'($urandom(99017));
		for (int i = 0; i < `LCD_CHARS; i++)
			localMem[i] = lcdChar_t'($urandom);
		rst = 1'b1;
		rotaryEvent = 1'b0;
		rotaryLeft = 1'b0;
		rotaryBtn = 1'b0;
		menuBtn = 1'b0;
		remoteDone = 1'b0;
		repeat (10) @(posedge clk);
		assert (!lcdWrite && !ramClear && !remoteEnable)
		else reportError("control outputs not low in reset");
		rst <= 1'b0;
		testReset();
		testRing();
		testShowLocal();
		testClear();
		testRemote(1'b0);
		testRemote(1'b1);
		testMenuButton();
		if (u_dut.u_sva.failCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/menuPkg.sv
rtl/lcdCopyIf.sv
rtl/lcdRefresher.sv
rtl/menuNavigator.sv
rtl/menuTop.sv
bench/menuTb_sva.sv
bench/menuTb.sv
